//--- mips_params.svh
`ifndef MIPS_PARAMS_SVH
`define MIPS_PARAMS_SVH

// Datapath and address width.
`define DATA_W 32

// Register destination width.
`define REG_ADDR_W 5

// CP0 register number plus select.
`define CP0_ADDR_W 8

// Data RAM depth in words.
`define RAM_WORDS 256

`endif

//--- mips_pkg.sv
package mips_pkg;

    // Cause codes plus an internal ERET marker.
    typedef enum logic [4:0] {
        EXC_INT  = 5'h00,
        EXC_ADEL = 5'h04,
        EXC_ADES = 5'h05,
        EXC_SYS  = 5'h08,
        EXC_BP   = 5'h09,
        EXC_RI   = 5'h0a,
        EXC_OV   = 5'h0c,
        EXC_ERET = 5'h1f
    } exc_code_e;

    // Hi in bit 1, lo in bit 0.
    typedef struct packed {
        logic hi;
        logic lo;
    } hilo_ena_t;

endpackage

//--- ex_mem_if.sv
`timescale 1ns/1ps
`include "mips_params.svh"

interface ex_mem_if;
    import mips_pkg::*;

    logic [`DATA_W-1:0]     pc;
    logic [`DATA_W-1:0]     alu_res;
    logic [`DATA_W-1:0]     ls_addr;

    hilo_ena_t              w_hilo_ena;
    logic [`DATA_W-1:0]     hi_res;
    logic [`DATA_W-1:0]     lo_res;

    // Exception flags carried from earlier stages.
    logic                   in_delay_slot;
    logic                   is_eret;
    logic                   is_syscall;
    logic                   is_break;
    logic                   is_inst_adel;
    logic                   is_data_adel;
    logic                   is_data_ades;
    logic                   is_overflow;
    logic                   is_ri;
    logic                   is_int;

    logic                   w_reg_ena;
    logic [`REG_ADDR_W-1:0] w_reg_dst;

    // Load/store control.
    logic                   ls_ena;
    logic [3:0]             ls_sel;
    logic                   wb_reg_sel;
    logic [`DATA_W-1:0]     rt_data;

    logic                   w_cp0_ena;
    logic [`CP0_ADDR_W-1:0] w_cp0_addr;
    logic [`DATA_W-1:0]     w_cp0_data;

    modport producer (
        output pc, alu_res, ls_addr,
        output w_hilo_ena, hi_res, lo_res,
        output in_delay_slot, is_eret, is_syscall, is_break, is_inst_adel,
        output is_data_adel, is_data_ades, is_overflow, is_ri, is_int,
        output w_reg_ena, w_reg_dst,
        output ls_ena, ls_sel, wb_reg_sel, rt_data,
        output w_cp0_ena, w_cp0_addr, w_cp0_data
    );

    modport consumer (
        input pc, alu_res, ls_addr,
        input w_hilo_ena, hi_res, lo_res,
        input in_delay_slot, is_eret, is_syscall, is_break, is_inst_adel,
        input is_data_adel, is_data_ades, is_overflow, is_ri, is_int,
        input w_reg_ena, w_reg_dst,
        input ls_ena, ls_sel, wb_reg_sel, rt_data,
        input w_cp0_ena, w_cp0_addr, w_cp0_data
    );

endinterface

//--- ex_mem.sv
`timescale 1ns/1ps

module ex_mem (
    input  logic          clk,
    input  logic          reset_i,
    input  logic          flush_i,
    input  logic          exception_flush_i,
    input  logic          stall_i,
    ex_mem_if.consumer    ex_in,
    ex_mem_if.producer    mem_out
);

    logic clear;
    logic capture;

    // Stall wins over a plain flush, not over an exception.
    assign clear   = reset_i || (flush_i && !stall_i) || exception_flush_i;
    assign capture = !flush_i && !stall_i;

    always_ff @(posedge clk) begin
        if (clear) begin
            mem_out.pc            <= '0;
            mem_out.alu_res       <= '0;
            mem_out.ls_addr       <= '0;
            mem_out.w_hilo_ena    <= '0;
            mem_out.hi_res        <= '0;
            mem_out.lo_res        <= '0;
            mem_out.in_delay_slot <= 1'b0;
            mem_out.is_eret       <= 1'b0;
            mem_out.is_syscall    <= 1'b0;
            mem_out.is_break      <= 1'b0;
            mem_out.is_inst_adel  <= 1'b0;
            mem_out.is_data_adel  <= 1'b0;
            mem_out.is_data_ades  <= 1'b0;
            mem_out.is_overflow   <= 1'b0;
            mem_out.is_ri         <= 1'b0;
            mem_out.is_int        <= 1'b0;
            mem_out.w_reg_ena     <= 1'b0;
            mem_out.w_reg_dst     <= '0;
            mem_out.ls_ena        <= 1'b0;
            mem_out.ls_sel        <= '0;
            mem_out.wb_reg_sel    <= 1'b0;
            mem_out.rt_data       <= '0;
            mem_out.w_cp0_ena     <= 1'b0;
            mem_out.w_cp0_addr    <= '0;
            mem_out.w_cp0_data    <= '0;
        end else if (capture) begin
            mem_out.pc            <= ex_in.pc;
            mem_out.alu_res       <= ex_in.alu_res;
            mem_out.ls_addr       <= ex_in.ls_addr;
            mem_out.w_hilo_ena    <= ex_in.w_hilo_ena;
            mem_out.hi_res        <= ex_in.hi_res;
            mem_out.lo_res        <= ex_in.lo_res;
            mem_out.in_delay_slot <= ex_in.in_delay_slot;
            mem_out.is_eret       <= ex_in.is_eret;
            mem_out.is_syscall    <= ex_in.is_syscall;
            mem_out.is_break      <= ex_in.is_break;
            mem_out.is_inst_adel  <= ex_in.is_inst_adel;
            mem_out.is_data_adel  <= ex_in.is_data_adel;
            mem_out.is_data_ades  <= ex_in.is_data_ades;
            mem_out.is_overflow   <= ex_in.is_overflow;
            mem_out.is_ri         <= ex_in.is_ri;
            mem_out.is_int        <= ex_in.is_int;
            mem_out.w_reg_ena     <= ex_in.w_reg_ena;
            mem_out.w_reg_dst     <= ex_in.w_reg_dst;
            mem_out.ls_ena        <= ex_in.ls_ena;
            mem_out.ls_sel        <= ex_in.ls_sel;
            mem_out.wb_reg_sel    <= ex_in.wb_reg_sel;
            mem_out.rt_data       <= ex_in.rt_data;
            mem_out.w_cp0_ena     <= ex_in.w_cp0_ena;
            mem_out.w_cp0_addr    <= ex_in.w_cp0_addr;
            mem_out.w_cp0_data    <= ex_in.w_cp0_data;
        end
        // Otherwise hold.
    end

endmodule

//--- exc_arbiter.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module exc_arbiter (
    ex_mem_if.consumer           stage,
    output logic                 exc_flush_o,
    output mips_pkg::exc_code_e  exc_code_o,
    output logic [`DATA_W-1:0]   epc_o,
    output logic [`DATA_W-1:0]   bad_vaddr_o
);
    import mips_pkg::*;

    logic any_exc;

    assign any_exc = stage.is_int
                  || stage.is_inst_adel
                  || stage.is_ri
                  || stage.is_overflow
                  || stage.is_syscall
                  || stage.is_break
                  || stage.is_data_adel
                  || stage.is_data_ades
                  || stage.is_eret;

    assign exc_flush_o = any_exc;

    // A delay-slot instruction restarts at its branch.
    assign epc_o = stage.in_delay_slot ? stage.pc - `DATA_W'd4 : stage.pc;

    // Highest priority first.
    always_comb begin
        exc_code_o  = EXC_INT;
        bad_vaddr_o = '0;
        if (stage.is_int) begin
            exc_code_o  = EXC_INT;
        end else if (stage.is_inst_adel) begin
            exc_code_o  = EXC_ADEL;
            bad_vaddr_o = stage.pc;
        end else if (stage.is_ri) begin
            exc_code_o  = EXC_RI;
        end else if (stage.is_overflow) begin
            exc_code_o  = EXC_OV;
        end else if (stage.is_syscall) begin
            exc_code_o  = EXC_SYS;
        end else if (stage.is_break) begin
            exc_code_o  = EXC_BP;
        end else if (stage.is_data_adel) begin
            exc_code_o  = EXC_ADEL;
            bad_vaddr_o = stage.ls_addr;
        end else if (stage.is_data_ades) begin
            exc_code_o  = EXC_ADES;
            bad_vaddr_o = stage.ls_addr;
        end else if (stage.is_eret) begin
            exc_code_o  = EXC_ERET;
        end
    end

endmodule

//--- mem_access.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module mem_access (
    ex_mem_if.consumer                        stage,
    input  logic                              kill_i,
    output logic                              ram_we_o,
    output logic [3:0]                        ram_be_o,
    output logic [$clog2(`RAM_WORDS)-1:0]     ram_addr_o,
    output logic [`DATA_W-1:0]                ram_wdata_o,
    input  logic [`DATA_W-1:0]                ram_rdata_i,
    output logic                              wb_reg_ena_o,
    output logic [`REG_ADDR_W-1:0]            wb_reg_dst_o,
    output logic [`DATA_W-1:0]                wb_data_o,
    output mips_pkg::hilo_ena_t               wb_hilo_ena_o,
    output logic [`DATA_W-1:0]                wb_hi_o,
    output logic [`DATA_W-1:0]                wb_lo_o,
    output logic                              wb_cp0_ena_o,
    output logic [`CP0_ADDR_W-1:0]            wb_cp0_addr_o,
    output logic [`DATA_W-1:0]                wb_cp0_data_o
);

    localparam int RAM_AW = $clog2(`RAM_WORDS);

    logic [1:0]          lo_lane;
    logic [4:0]          lane_shift;
    logic [`DATA_W-1:0]  byte_mask;
    logic [`DATA_W-1:0]  load_data;

    // Lowest enabled byte sets the alignment.
    always_comb begin
        casez (stage.ls_sel)
            4'b???1: lo_lane = 2'd0;
            4'b??10: lo_lane = 2'd1;
            4'b?100: lo_lane = 2'd2;
            4'b1000: lo_lane = 2'd3;
            default: lo_lane = 2'd0;
        endcase
    end

    assign lane_shift = {lo_lane, 3'b000};

    always_comb begin
        for (int b = 0; b < 4; b++) begin
            byte_mask[8*b +: 8] = {8{stage.ls_sel[b]}};
        end
    end

    assign ram_addr_o  = stage.ls_addr[RAM_AW+1:2];
    assign ram_be_o    = stage.ls_sel;
    assign ram_wdata_o = stage.rt_data << lane_shift;
    assign ram_we_o    = stage.ls_ena && (stage.ls_sel != 4'b0000)
                      && !stage.wb_reg_sel && !kill_i;

    // Loads are zero-extended.
    assign load_data = (ram_rdata_i & byte_mask) >> lane_shift;
    assign wb_data_o = stage.wb_reg_sel ? load_data : stage.alu_res;

    assign wb_reg_dst_o  = stage.w_reg_dst;
    assign wb_hi_o       = stage.hi_res;
    assign wb_lo_o       = stage.lo_res;
    assign wb_cp0_addr_o = stage.w_cp0_addr;
    assign wb_cp0_data_o = stage.w_cp0_data;

    always_comb begin
        wb_reg_ena_o  = stage.w_reg_ena && !kill_i;
        wb_cp0_ena_o  = stage.w_cp0_ena && !kill_i;
        wb_hilo_ena_o = stage.w_hilo_ena;
        if (kill_i) begin
            wb_hilo_ena_o = '0;
        end
    end

endmodule

//--- data_ram.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module data_ram (
    input  logic                          clk,
    input  logic                          we_i,
    input  logic [3:0]                    be_i,
    input  logic [$clog2(`RAM_WORDS)-1:0] addr_i,
    input  logic [`DATA_W-1:0]            wdata_i,
    output logic [`DATA_W-1:0]            rdata_o
);

    logic [`DATA_W-1:0] mem [`RAM_WORDS];

    // Byte-lane write.
    always_ff @(posedge clk) begin
        if (we_i) begin
            for (int b = 0; b < 4; b++) begin
                if (be_i[b]) begin
                    mem[addr_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
    end

    // Asynchronous read.
    assign rdata_o = mem[addr_i];

endmodule

//--- mem_stage_top.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module mem_stage_top (
    input  logic                          clk,
    input  logic                          reset_i,
    input  logic                          stall_i,
    input  logic                          flush_i,

    input  logic [`DATA_W-1:0]            ex_pc_i,
    input  logic [`DATA_W-1:0]            ex_alu_res_i,
    input  logic [`DATA_W-1:0]            ex_ls_addr_i,
    input  mips_pkg::hilo_ena_t           ex_w_hilo_ena_i,
    input  logic [`DATA_W-1:0]            ex_hi_res_i,
    input  logic [`DATA_W-1:0]            ex_lo_res_i,
    input  logic                          ex_in_delay_slot_i,
    input  logic                          ex_is_eret_i,
    input  logic                          ex_is_syscall_i,
    input  logic                          ex_is_break_i,
    input  logic                          ex_is_inst_adel_i,
    input  logic                          ex_is_data_adel_i,
    input  logic                          ex_is_data_ades_i,
    input  logic                          ex_is_overflow_i,
    input  logic                          ex_is_ri_i,
    input  logic                          ex_is_int_i,
    input  logic                          ex_w_reg_ena_i,
    input  logic [`REG_ADDR_W-1:0]        ex_w_reg_dst_i,
    input  logic                          ex_ls_ena_i,
    input  logic [3:0]                    ex_ls_sel_i,
    input  logic                          ex_wb_reg_sel_i,
    input  logic [`DATA_W-1:0]            ex_rt_data_i,
    input  logic                          ex_w_cp0_ena_i,
    input  logic [`CP0_ADDR_W-1:0]        ex_w_cp0_addr_i,
    input  logic [`DATA_W-1:0]            ex_w_cp0_data_i,

    output logic                          wb_reg_ena_o,
    output logic [`REG_ADDR_W-1:0]        wb_reg_dst_o,
    output logic [`DATA_W-1:0]            wb_data_o,
    output mips_pkg::hilo_ena_t           wb_hilo_ena_o,
    output logic [`DATA_W-1:0]            wb_hi_o,
    output logic [`DATA_W-1:0]            wb_lo_o,
    output logic                          wb_cp0_ena_o,
    output logic [`CP0_ADDR_W-1:0]        wb_cp0_addr_o,
    output logic [`DATA_W-1:0]            wb_cp0_data_o,

    output logic                          exc_flush_o,
    output mips_pkg::exc_code_e           exc_code_o,
    output logic [`DATA_W-1:0]            epc_o,
    output logic [`DATA_W-1:0]            bad_vaddr_o
);

    logic                          exc_flush;
    logic                          ram_we;
    logic [3:0]                    ram_be;
    logic [$clog2(`RAM_WORDS)-1:0] ram_addr;
    logic [`DATA_W-1:0]            ram_wdata;
    logic [`DATA_W-1:0]            ram_rdata;

    ex_mem_if ex_bus ();
    ex_mem_if mem_bus ();

    // Execute-stage results onto the input bus.
    assign ex_bus.pc            = ex_pc_i;
    assign ex_bus.alu_res       = ex_alu_res_i;
    assign ex_bus.ls_addr       = ex_ls_addr_i;
    assign ex_bus.w_hilo_ena    = ex_w_hilo_ena_i;
    assign ex_bus.hi_res        = ex_hi_res_i;
    assign ex_bus.lo_res        = ex_lo_res_i;
    assign ex_bus.in_delay_slot = ex_in_delay_slot_i;
    assign ex_bus.is_eret       = ex_is_eret_i;
    assign ex_bus.is_syscall    = ex_is_syscall_i;
    assign ex_bus.is_break      = ex_is_break_i;
    assign ex_bus.is_inst_adel  = ex_is_inst_adel_i;
    assign ex_bus.is_data_adel  = ex_is_data_adel_i;
    assign ex_bus.is_data_ades  = ex_is_data_ades_i;
    assign ex_bus.is_overflow   = ex_is_overflow_i;
    assign ex_bus.is_ri         = ex_is_ri_i;
    assign ex_bus.is_int        = ex_is_int_i;
    assign ex_bus.w_reg_ena     = ex_w_reg_ena_i;
    assign ex_bus.w_reg_dst     = ex_w_reg_dst_i;
    assign ex_bus.ls_ena        = ex_ls_ena_i;
    assign ex_bus.ls_sel        = ex_ls_sel_i;
    assign ex_bus.wb_reg_sel    = ex_wb_reg_sel_i;
    assign ex_bus.rt_data       = ex_rt_data_i;
    assign ex_bus.w_cp0_ena     = ex_w_cp0_ena_i;
    assign ex_bus.w_cp0_addr    = ex_w_cp0_addr_i;
    assign ex_bus.w_cp0_data    = ex_w_cp0_data_i;

    assign exc_flush_o = exc_flush;

    ex_mem u_ex_mem (
        .clk               (clk),
        .reset_i           (reset_i),
        .flush_i           (flush_i),
        .exception_flush_i (exc_flush),
        .stall_i           (stall_i),
        .ex_in             (ex_bus.consumer),
        .mem_out           (mem_bus.producer)
    );

    exc_arbiter u_exc_arbiter (
        .stage       (mem_bus.consumer),
        .exc_flush_o (exc_flush),
        .exc_code_o  (exc_code_o),
        .epc_o       (epc_o),
        .bad_vaddr_o (bad_vaddr_o)
    );

    mem_access u_mem_access (
        .stage         (mem_bus.consumer),
        .kill_i        (exc_flush),
        .ram_we_o      (ram_we),
        .ram_be_o      (ram_be),
        .ram_addr_o    (ram_addr),
        .ram_wdata_o   (ram_wdata),
        .ram_rdata_i   (ram_rdata),
        .wb_reg_ena_o  (wb_reg_ena_o),
        .wb_reg_dst_o  (wb_reg_dst_o),
        .wb_data_o     (wb_data_o),
        .wb_hilo_ena_o (wb_hilo_ena_o),
        .wb_hi_o       (wb_hi_o),
        .wb_lo_o       (wb_lo_o),
        .wb_cp0_ena_o  (wb_cp0_ena_o),
        .wb_cp0_addr_o (wb_cp0_addr_o),
        .wb_cp0_data_o (wb_cp0_data_o)
    );

    data_ram u_data_ram (
        .clk     (clk),
        .we_i    (ram_we),
        .be_i    (ram_be),
        .addr_i  (ram_addr),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

endmodule

//--- tb_mem_stage.sv
`timescale 1ns/1ps
`include "mips_params.svh"

module tb_mem_stage;
    import mips_pkg::*;

    // Writeback-side fields of one instruction.
    typedef struct packed {
        logic [`DATA_W-1:0]     alu_res;
        logic                   reg_ena;
        logic [`REG_ADDR_W-1:0] reg_dst;
        hilo_ena_t              hilo;
        logic [`DATA_W-1:0]     hi;
        logic [`DATA_W-1:0]     lo;
        logic                   cp0_ena;
        logic [`CP0_ADDR_W-1:0] cp0_addr;
        logic [`DATA_W-1:0]     cp0_data;
    } wb_fields_t;

    logic                   clk = 1'b0;
    logic                   reset_i;
    logic                   stall_i;
    logic                   flush_i;
    logic [`DATA_W-1:0]     ex_pc_i;
    logic [`DATA_W-1:0]     ex_alu_res_i;
    logic [`DATA_W-1:0]     ex_ls_addr_i;
    hilo_ena_t              ex_w_hilo_ena_i;
    logic [`DATA_W-1:0]     ex_hi_res_i;
    logic [`DATA_W-1:0]     ex_lo_res_i;
    logic                   ex_in_delay_slot_i;
    logic                   ex_is_eret_i;
    logic                   ex_is_syscall_i;
    logic                   ex_is_break_i;
    logic                   ex_is_inst_adel_i;
    logic                   ex_is_data_adel_i;
    logic                   ex_is_data_ades_i;
    logic                   ex_is_overflow_i;
    logic                   ex_is_ri_i;
    logic                   ex_is_int_i;
    logic                   ex_w_reg_ena_i;
    logic [`REG_ADDR_W-1:0] ex_w_reg_dst_i;
    logic                   ex_ls_ena_i;
    logic [3:0]             ex_ls_sel_i;
    logic                   ex_wb_reg_sel_i;
    logic [`DATA_W-1:0]     ex_rt_data_i;
    logic                   ex_w_cp0_ena_i;
    logic [`CP0_ADDR_W-1:0] ex_w_cp0_addr_i;
    logic [`DATA_W-1:0]     ex_w_cp0_data_i;
    logic                   wb_reg_ena_o;
    logic [`REG_ADDR_W-1:0] wb_reg_dst_o;
    logic [`DATA_W-1:0]     wb_data_o;
    hilo_ena_t              wb_hilo_ena_o;
    logic [`DATA_W-1:0]     wb_hi_o;
    logic [`DATA_W-1:0]     wb_lo_o;
    logic                   wb_cp0_ena_o;
    logic [`CP0_ADDR_W-1:0] wb_cp0_addr_o;
    logic [`DATA_W-1:0]     wb_cp0_data_o;
    logic                   exc_flush_o;
    exc_code_e              exc_code_o;
    logic [`DATA_W-1:0]     epc_o;
    logic [`DATA_W-1:0]     bad_vaddr_o;

    logic [`DATA_W-1:0] ref_mem [`RAM_WORDS];
    logic [7:0]         test_words [8];
    logic [3:0]         test_sels [8];
    logic [3:0]         sel_list [4] = '{4'b1111, 4'b0011, 4'b1100, 4'b0100};
    // Flag bits in priority order with bit 0 highest.
    exc_code_e          prio_code [9] = '{EXC_INT, EXC_ADEL, EXC_RI, EXC_OV, EXC_SYS,
                                          EXC_BP, EXC_ADEL, EXC_ADES, EXC_ERET};
    int                 errors;
    int                 seed;

    mem_stage_top UUT (.*);

    always #50 clk = ~clk;

    initial begin
        #1_000_000;
        $display("Simulation timed out before all tests completed.");
        $display("test failed");
        $finish;
    end

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    function automatic wb_fields_t random_wb();
        wb_fields_t  f;
        logic [31:0] r;
        r          = rand32();
        f.alu_res  = rand32();
        f.reg_ena  = 1'b1;
        f.reg_dst  = r[4:0];
        f.hilo.hi  = r[9];
        f.hilo.lo  = r[8];
        f.hi       = rand32();
        f.lo       = rand32();
        f.cp0_ena  = r[12];
        f.cp0_addr = r[23:16];
        f.cp0_data = rand32();
        return f;
    endfunction

    function automatic logic [31:0] word_addr(input logic [7:0] word);
        return {{(`DATA_W-10){1'b0}}, word, 2'b00};
    endfunction

    // Enabled bytes packed down from bit 0.
    function automatic logic [31:0] load_expect(input logic [31:0] word, input logic [3:0] sel);
        logic [31:0] r;
        int          k;
        r = '0;
        k = 0;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                r[8*k +: 8] = word[8*b +: 8];
                k++;
            end
        end
        return r;
    endfunction

    task automatic model_store(input logic [7:0] word, input logic [3:0] sel,
                               input logic [31:0] data);
        int k;
        k = 0;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                ref_mem[word][8*b +: 8] = data[8*k +: 8];
                k++;
            end
        end
    endtask

    task automatic compare_value(input string name, input logic [31:0] exp,
                                 input logic [31:0] act);
        assert (act === exp) else begin
            errors++;
            $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic verify_writeback(input string name, input wb_fields_t f);
        compare_value({name, " reg_ena"}, 32'(f.reg_ena), 32'(wb_reg_ena_o));
        compare_value({name, " reg_dst"}, 32'(f.reg_dst), 32'(wb_reg_dst_o));
        compare_value({name, " wb_data"}, f.alu_res, wb_data_o);
        compare_value({name, " hilo_ena"}, {30'd0, f.hilo}, {30'd0, wb_hilo_ena_o});
        compare_value({name, " hi"}, f.hi, wb_hi_o);
        compare_value({name, " lo"}, f.lo, wb_lo_o);
        compare_value({name, " cp0_ena"}, 32'(f.cp0_ena), 32'(wb_cp0_ena_o));
        compare_value({name, " cp0_addr"}, 32'(f.cp0_addr), 32'(wb_cp0_addr_o));
        compare_value({name, " cp0_data"}, f.cp0_data, wb_cp0_data_o);
    endtask

    task automatic apply_wb(input wb_fields_t f);
        ex_alu_res_i    <= f.alu_res;
        ex_w_reg_ena_i  <= f.reg_ena;
        ex_w_reg_dst_i  <= f.reg_dst;
        ex_w_hilo_ena_i <= f.hilo;
        ex_hi_res_i     <= f.hi;
        ex_lo_res_i     <= f.lo;
        ex_w_cp0_ena_i  <= f.cp0_ena;
        ex_w_cp0_addr_i <= f.cp0_addr;
        ex_w_cp0_data_i <= f.cp0_data;
    endtask

    task automatic apply_mem_op(input logic [31:0] addr, input logic [3:0] sel,
                                input logic is_load, input logic [31:0] rt);
        ex_ls_ena_i     <= 1'b1;
        ex_ls_sel_i     <= sel;
        ex_wb_reg_sel_i <= is_load;
        ex_w_reg_ena_i  <= is_load;
        ex_ls_addr_i    <= addr;
        ex_rt_data_i    <= rt;
    endtask

    task automatic set_flags(input logic [8:0] flags);
        ex_is_int_i       <= flags[0];
        ex_is_inst_adel_i <= flags[1];
        ex_is_ri_i        <= flags[2];
        ex_is_overflow_i  <= flags[3];
        ex_is_syscall_i   <= flags[4];
        ex_is_break_i     <= flags[5];
        ex_is_data_adel_i <= flags[6];
        ex_is_data_ades_i <= flags[7];
        ex_is_eret_i      <= flags[8];
    endtask

    task automatic go_idle();
        apply_wb('0);
        set_flags('0);
        apply_mem_op('0, 4'b0000, 1'b0, '0);
        ex_ls_ena_i        <= 1'b0;
        ex_pc_i            <= '0;
        ex_in_delay_slot_i <= 1'b0;
    endtask

    // Capture edge, then sample mid-cycle.
    task automatic capture_cycle();
        @(posedge clk);
        go_idle();
        @(negedge clk);
    endtask

    task automatic wait_flush_low(input string name);
        int cycles;
        cycles = 0;
        while (exc_flush_o === 1'b1 && cycles < 8) begin
            @(negedge clk);
            cycles++;
        end
        assert (exc_flush_o !== 1'b1) else begin
            errors++;
            $display("%s: timed out waiting for the exception flush to drop", name);
        end
        if (exc_flush_o !== 1'b1) begin
            compare_value({name, " clear latency"}, 32'd1, cycles);
        end
    endtask

    task automatic verify_loads(input string name);
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            apply_mem_op(word_addr(test_words[i]), test_sels[i], 1'b1, '0);
            capture_cycle();
            compare_value({name, " data"}, load_expect(ref_mem[test_words[i]], test_sels[i]),
                          wb_data_o);
            compare_value({name, " reg_ena"}, 32'd1, 32'(wb_reg_ena_o));
        end
    endtask

    task automatic reset_and_pass_through();
        wb_fields_t f;
        f = random_wb();
        verify_writeback("reset", '0);
        compare_value("reset exc_flush", 32'd0, 32'(exc_flush_o));
        @(posedge clk);
        apply_wb(f);
        capture_cycle();
        verify_writeback("pass_through", f);
        compare_value("pass_through exc_flush", 32'd0, 32'(exc_flush_o));
    endtask

    task automatic stall_and_flush();
        wb_fields_t a;
        wb_fields_t b;
        a = random_wb();
        b = random_wb();
        @(posedge clk);
        apply_wb(a);
        @(posedge clk);
        apply_wb(b);
        stall_i <= 1'b1;
        @(negedge clk);
        verify_writeback("stall_capture", a);
        @(posedge clk);
        flush_i <= 1'b1;
        @(negedge clk);
        verify_writeback("stall_hold", a);
        @(posedge clk);
        stall_i <= 1'b0;
        @(negedge clk);
        verify_writeback("flush_with_stall", a);
        @(posedge clk);
        flush_i <= 1'b0;
        go_idle();
        @(negedge clk);
        verify_writeback("flush_clear", '0);
    endtask

    task automatic store_then_load();
        logic [31:0] base;
        logic [31:0] data;
        base = rand32();
        for (int i = 0; i < 8; i++) begin
            test_words[i] = base[7:0] + 8'(i * 5);
            test_sels[i]  = sel_list[i % 4];
            data          = rand32();
            model_store(test_words[i], test_sels[i], data);
            @(posedge clk);
            apply_mem_op(word_addr(test_words[i]), test_sels[i], 1'b0, data);
            capture_cycle();
            compare_value("store_then_load exc_flush", 32'd0, 32'(exc_flush_o));
            compare_value("store_then_load reg_ena", 32'd0, 32'(wb_reg_ena_o));
        end
        verify_loads("store_then_load");
    endtask

    task automatic exception_priority();
        logic [8:0]  flags;
        logic [31:0] r;
        logic [31:0] pc;
        logic [31:0] addr;
        logic [31:0] exp_bad;
        logic [31:0] exp_epc;
        logic        ds;
        int          lvl;
        int          top;
        for (int n = 0; n < 24; n++) begin
            r     = rand32();
            // Lowest set flag steps through every priority level.
            lvl   = n % 9;
            flags = r[8:0] & (9'h1ff << lvl);
            flags[lvl] = 1'b1;
            ds        = r[16];
            pc        = rand32();
            pc[1:0]   = 2'b00;
            addr      = rand32();
            addr[9:2] = test_words[n % 8];
            top       = 0;
            for (int i = 8; i >= 0; i--) begin
                if (flags[i]) begin
                    top = i;
                end
            end
            exp_bad = '0;
            if (top == 1) begin
                exp_bad = pc;
            end else if (top == 6 || top == 7) begin
                exp_bad = addr;
            end
            exp_epc = pc;
            if (ds) begin
                exp_epc = pc - 32'd4;
            end
            @(posedge clk);
            apply_mem_op(addr, 4'b1111, 1'b0, rand32());
            apply_wb(random_wb());
            set_flags(flags);
            ex_pc_i            <= pc;
            ex_in_delay_slot_i <= ds;
            @(posedge clk);
            go_idle();
            stall_i <= 1'b1;
            @(negedge clk);
            compare_value("exception flush", 32'd1, 32'(exc_flush_o));
            compare_value("exception code", 32'(prio_code[top]), 32'(exc_code_o));
            compare_value("exception epc", exp_epc, epc_o);
            compare_value("exception bad_vaddr", exp_bad, bad_vaddr_o);
            compare_value("exception reg_ena", 32'd0, 32'(wb_reg_ena_o));
            compare_value("exception cp0_ena", 32'd0, 32'(wb_cp0_ena_o));
            compare_value("exception hilo_ena", 32'd0, {30'd0, wb_hilo_ena_o});
            wait_flush_low("exception");
            verify_writeback("exception_clear", '0);
            @(posedge clk);
            stall_i <= 1'b0;
        end
        // Every cancelled store hit a tracked word.
        verify_loads("exception_no_store");
    endtask

    task automatic eret_and_cp0();
        wb_fields_t f;
        @(posedge clk);
        set_flags(9'h100);
        ex_pc_i <= 32'h0000_0400;
        capture_cycle();
        compare_value("eret flush", 32'd1, 32'(exc_flush_o));
        compare_value("eret code", 32'(EXC_ERET), 32'(exc_code_o));
        wait_flush_low("eret");
        f = random_wb();
        f.cp0_ena = 1'b1;
        @(posedge clk);
        apply_wb(f);
        capture_cycle();
        compare_value("cp0_write exc_flush", 32'd0, 32'(exc_flush_o));
        verify_writeback("cp0_write", f);
    endtask

    initial begin
        errors = 0;
        seed   = 61;
        reset_i <= 1'b1;
        stall_i <= 1'b0;
        flush_i <= 1'b0;
        go_idle();
        repeat (5) @(posedge clk);
        reset_i <= 1'b0;
        @(negedge clk);
        reset_and_pass_through();
        stall_and_flush();
        store_then_load();
        exception_priority();
        eret_and_cp0();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+.
mips_pkg.sv
ex_mem_if.sv
ex_mem.sv
exc_arbiter.sv
mem_access.sv
data_ram.sv
mem_stage_top.sv
tb_mem_stage.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and judge the result from the log.
rm -f sim.log
verilator --binary --timing --assert -f src.f --top-module tb_mem_stage -o sim_mem_stage \
    && ./obj_dir/sim_mem_stage | tee sim.log \
    || echo "Build or simulation did not complete."
grep -qx "test passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
